//--- design/soc_pkg.sv
`default_nettype none

package soc_pkg;

   ////////////////////////////////////////
   // native bus widths
   ////////////////////////////////////////
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   // one strobe per byte, all zero means read
   localparam int STRB_W = 4;

   // decoded slaves on the s_valid / s_ready vectors
   localparam int N_SLAVES = 3;
   localparam int SLV_BOOT = 0;
   localparam int SLV_MAIN = 1;
   localparam int SLV_UART = 2;

   ////////////////////////////////////////
   // address map
   ////////////////////////////////////////
   // region is the top REGION_W address bits
   localparam int REGION_W = 3;
   localparam logic [REGION_W-1:0] REGION_BOOT = 3'd0;
   localparam logic [REGION_W-1:0] REGION_MAIN = 3'd1;
   localparam logic [REGION_W-1:0] REGION_UART = 3'd2;

   // soft reset trigger, sits in unmapped region 3
   localparam logic [ADDR_W-1:0] SOFT_RESET_ADDR = 32'h6fff_fffc;
   // core reset pulse length after a soft reset
   localparam int SOFT_RESET_CYCLES = 5;

   ////////////////////////////////////////
   // uart registers, word index addr[4:2]
   ////////////////////////////////////////
   localparam logic [2:0] UART_TXDATA = 3'd0;
   // bit 0 tx busy, bit 1 rx valid
   localparam logic [2:0] UART_STATUS = 3'd1;
   localparam logic [2:0] UART_RXDATA = 3'd2;
   localparam logic [2:0] UART_DIV    = 3'd3;

endpackage

`default_nettype wire

//--- design/reset_control.sv
`default_nettype none

module reset_control #(
   parameter int RESET_CNT_W = 11
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       m_valid,
   input  logic [soc_pkg::ADDR_W-1:0] m_addr,
   input  logic [soc_pkg::STRB_W-1:0] m_wstrb,
   output logic                       mem_sel,
   output logic                       core_reset,
   output logic                       sys_ready
);
   import soc_pkg::*;

   // wide enough to hold the soft reset length
   localparam int SOFT_CNT_W = $clog2(SOFT_RESET_CYCLES + 1);

   logic [RESET_CNT_W-1:0] por_cnt;
   logic                   soft_hit;
   logic                   soft_hit_q;
   logic                   soft_accept;
   logic [SOFT_CNT_W-1:0]  soft_cnt;

   ////////////////////////////////////////
   // power-on counter
   ////////////////////////////////////////
   // counts up until the top bit sets, then holds
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         por_cnt <= '0;
      end else if (!por_cnt[RESET_CNT_W-1]) begin
         por_cnt <= por_cnt + 1'b1;
      end
   end

   assign sys_ready = por_cnt[RESET_CNT_W-1];

   ////////////////////////////////////////
   // soft reset detector
   ////////////////////////////////////////
   // write to the trigger address
   assign soft_hit = m_valid && (m_addr == SOFT_RESET_ADDR) && (|m_wstrb);

   // mirrors the slave ready pulse so the held access counts once
   assign soft_accept = soft_hit && !soft_hit_q;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         soft_hit_q <= 1'b0;
         mem_sel    <= 1'b0;
         soft_cnt   <= '0;
      end else begin
         soft_hit_q <= soft_accept;
         if (soft_accept) begin
            // remap is sticky until the next hard reset
            mem_sel  <= 1'b1;
            soft_cnt <= SOFT_CNT_W'(SOFT_RESET_CYCLES);
         end else if (soft_cnt != '0) begin
            soft_cnt <= soft_cnt - 1'b1;
         end
      end
   end

   // core held in reset until power-on done or while pulse runs
   assign core_reset = !sys_ready || (soft_cnt != '0);

endmodule

`default_nettype wire

//--- design/bus_interconnect.sv
`default_nettype none

module bus_interconnect (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         mem_sel,
   input  logic                         m_valid,
   input  logic [soc_pkg::ADDR_W-1:0]   m_addr,
   output logic [soc_pkg::N_SLAVES-1:0] s_valid,
   output logic [soc_pkg::DATA_W-1:0]   m_rdata,
   output logic                         m_ready,
   input  logic [soc_pkg::DATA_W-1:0]   boot_rdata,
   input  logic [soc_pkg::DATA_W-1:0]   main_rdata,
   input  logic [soc_pkg::DATA_W-1:0]   uart_rdata,
   input  logic [soc_pkg::N_SLAVES-1:0] s_ready
);
   import soc_pkg::*;

   logic [REGION_W-1:0] region;
   logic [N_SLAVES-1:0] sel;
   logic                unmapped;
   logic                unm_ready;

   ////////////////////////////////////////
   // region decode
   ////////////////////////////////////////
   assign region = m_addr[ADDR_W-1 -: REGION_W];

   always_comb begin
      sel      = '0;
      unmapped = 1'b0;
      case (region)
         // boot region follows the remap flag
         REGION_BOOT: begin
            if (mem_sel) begin
               sel[SLV_MAIN] = 1'b1;
            end else begin
               sel[SLV_BOOT] = 1'b1;
            end
         end
         REGION_MAIN: sel[SLV_MAIN] = 1'b1;
         REGION_UART: sel[SLV_UART] = 1'b1;
         // everything else goes to the local responder
         default:     unmapped = 1'b1;
      endcase
   end

   // exactly one slave sees valid
   assign s_valid = {N_SLAVES{m_valid}} & sel;

   ////////////////////////////////////////
   // unmapped responder
   ////////////////////////////////////////
   // same one-cycle pulse rule as the slaves
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         unm_ready <= 1'b0;
      end else begin
         unm_ready <= m_valid && unmapped && !unm_ready;
      end
   end

   ////////////////////////////////////////
   // return path
   ////////////////////////////////////////
   // address is held until ready, so decode selects the return
   always_comb begin
      m_rdata = '0;
      m_ready = 1'b0;
      if (sel[SLV_BOOT]) begin
         m_rdata = boot_rdata;
         m_ready = s_ready[SLV_BOOT];
      end else if (sel[SLV_MAIN]) begin
         m_rdata = main_rdata;
         m_ready = s_ready[SLV_MAIN];
      end else if (sel[SLV_UART]) begin
         m_rdata = uart_rdata;
         m_ready = s_ready[SLV_UART];
      end else begin
         // unmapped reads return zero
         m_ready = unm_ready;
      end
   end

endmodule

`default_nettype wire

//--- design/sram_bank.sv
`default_nettype none

module sram_bank #(
   parameter int ADDR_W = 12
) (
   input  logic                       clk,
   input  logic                       valid,
   input  logic [ADDR_W-1:0]          addr,
   input  logic [soc_pkg::DATA_W-1:0] wdata,
   input  logic [soc_pkg::STRB_W-1:0] wstrb,
   output logic [soc_pkg::DATA_W-1:0] rdata,
   output logic                       ready
);
   import soc_pkg::*;

   // byte address width in, word array out
   localparam int WORDS = 2 ** (ADDR_W - 2);

   logic [DATA_W-1:0] mem [WORDS];
   logic [ADDR_W-3:0] word_idx;
   logic              accept;

   assign word_idx = addr[ADDR_W-1:2];

   // first cycle of valid only
   assign accept = valid && !ready;

   ////////////////////////////////////////
   // array access
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (accept) begin
         // merge strobed bytes
         for (int b = 0; b < STRB_W; b++) begin
            if (wstrb[b]) begin
               mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
            end
         end
         // old word, valid alongside ready
         rdata <= mem[word_idx];
      end
   end

   ////////////////////////////////////////
   // ready pulse
   ////////////////////////////////////////
   // valid is low while no access runs, which clears this
   always_ff @(posedge clk) begin
      ready <= accept;
   end

endmodule

`default_nettype wire

//--- design/uart_core.sv
`default_nettype none

module uart_core #(
   parameter int UART_DIV_RESET = 868
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       valid,
   input  logic [2:0]                 addr,
   input  logic [soc_pkg::DATA_W-1:0] wdata,
   input  logic [soc_pkg::STRB_W-1:0] wstrb,
   output logic [soc_pkg::DATA_W-1:0] rdata,
   output logic                       ready,
   input  logic                       ser_rx,
   output logic                       ser_tx
);
   import soc_pkg::*;

   // cycles per bit
   localparam int DIV_W = 16;

   logic              accept;
   logic              wr;
   logic              rd;
   logic              tx_start;
   logic              rx_clear;
   logic [DIV_W-1:0]  div;
   logic [DATA_W-1:0] rd_word;

   logic [9:0]        tx_shreg;
   logic              tx_busy;
   logic [3:0]        tx_bit;
   logic [DIV_W-1:0]  tx_baud;

   logic [1:0]        rx_sync;
   logic              rx_busy;
   logic [3:0]        rx_bit;
   logic [DIV_W-1:0]  rx_baud;
   logic [7:0]        rx_shreg;
   logic [7:0]        rx_data;
   logic              rx_tick;
   logic              rx_done;
   logic              rx_valid;

   ////////////////////////////////////////
   // register interface
   ////////////////////////////////////////
   assign accept   = valid && !ready;
   assign wr       = accept && (|wstrb);
   assign rd       = accept && !(|wstrb);
   // writes while busy are dropped
   assign tx_start = wr && (addr == UART_TXDATA) && wstrb[0] && !tx_busy;
   assign rx_clear = rd && (addr == UART_RXDATA);

   always_comb begin
      case (addr)
         UART_STATUS: rd_word = {{(DATA_W-2){1'b0}}, rx_valid, tx_busy};
         UART_RXDATA: rd_word = {{(DATA_W-8){1'b0}}, rx_data};
         UART_DIV:    rd_word = {{(DATA_W-DIV_W){1'b0}}, div};
         default:     rd_word = '0;
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready <= 1'b0;
         div   <= DIV_W'(UART_DIV_RESET);
      end else begin
         ready <= accept;
         // divisor takes the two low bytes
         if (wr && (addr == UART_DIV)) begin
            if (wstrb[0]) begin
               div[7:0] <= wdata[7:0];
            end
            if (wstrb[1]) begin
               div[15:8] <= wdata[15:8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         rdata <= rd_word;
      end
   end

   ////////////////////////////////////////
   // transmitter
   ////////////////////////////////////////
   // stop, data lsb first, start, shifted out from bit 0
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         tx_shreg <= '1;
         tx_busy  <= 1'b0;
         tx_bit   <= '0;
         tx_baud  <= '0;
      end else if (tx_start) begin
         tx_shreg <= {1'b1, wdata[7:0], 1'b0};
         tx_busy  <= 1'b1;
         tx_bit   <= '0;
         tx_baud  <= '0;
      end else if (tx_busy) begin
         if (tx_baud == div - 1'b1) begin
            tx_baud  <= '0;
            tx_shreg <= {1'b1, tx_shreg[9:1]};
            // busy drops at the end of the stop bit
            if (tx_bit == 4'd9) begin
               tx_busy <= 1'b0;
            end else begin
               tx_bit <= tx_bit + 1'b1;
            end
         end else begin
            tx_baud <= tx_baud + 1'b1;
         end
      end
   end

   // idles high since the shifter fills with ones
   assign ser_tx = tx_shreg[0];

   ////////////////////////////////////////
   // receiver
   ////////////////////////////////////////
   assign rx_tick = rx_busy && (rx_baud == '0);
   // stop bit sampled high
   assign rx_done = rx_tick && (rx_bit == 4'd9) && rx_sync[1];

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rx_sync <= '1;
         rx_busy <= 1'b0;
         rx_bit  <= '0;
         rx_baud <= '0;
      end else begin
         rx_sync <= {rx_sync[0], ser_rx};
         if (!rx_busy) begin
            // falling start edge, wait half a bit
            if (!rx_sync[1]) begin
               rx_busy <= 1'b1;
               rx_bit  <= '0;
               rx_baud <= div >> 1;
            end
         end else if (!rx_tick) begin
            rx_baud <= rx_baud - 1'b1;
         end else begin
            rx_baud <= div - 1'b1;
            rx_bit  <= rx_bit + 1'b1;
            // glitch on start bit aborts
            if ((rx_bit == 4'd0) && rx_sync[1]) begin
               rx_busy <= 1'b0;
            end
            if (rx_bit == 4'd9) begin
               rx_busy <= 1'b0;
            end
         end
      end
   end

   // data bits 1..8 shift in lsb first
   always_ff @(posedge clk) begin
      if (rx_tick && (rx_bit != 4'd0) && (rx_bit != 4'd9)) begin
         rx_shreg <= {rx_sync[1], rx_shreg[7:1]};
      end
      if (rx_done) begin
         rx_data <= rx_shreg;
      end
   end

   // new byte wins over a same-cycle read
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rx_valid <= 1'b0;
      end else if (rx_done) begin
         rx_valid <= 1'b1;
      end else if (rx_clear) begin
         rx_valid <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- design/soc_system.sv
`default_nettype none

module soc_system #(
   parameter int BOOT_ADDR_W    = 12,
   parameter int MAIN_ADDR_W    = 14,
   parameter int RESET_CNT_W    = 11,
   parameter int UART_DIV_RESET = 868
) (
   input  logic                       clk,
   input  logic                       reset,
   // native master port
   input  logic                       m_valid,
   input  logic [soc_pkg::ADDR_W-1:0] m_addr,
   input  logic [soc_pkg::DATA_W-1:0] m_wdata,
   input  logic [soc_pkg::STRB_W-1:0] m_wstrb,
   output logic [soc_pkg::DATA_W-1:0] m_rdata,
   output logic                       m_ready,
   // system control
   output logic                       core_reset,
   output logic                       sys_ready,
   output logic                       mem_sel,
   // serial line
   input  logic                       ser_rx,
   output logic                       ser_tx
);
   import soc_pkg::*;

   logic [N_SLAVES-1:0] s_valid;
   logic [N_SLAVES-1:0] s_ready;
   logic [DATA_W-1:0]   boot_rdata;
   logic [DATA_W-1:0]   main_rdata;
   logic [DATA_W-1:0]   uart_rdata;

   ////////////////////////////////////////
   // reset and remap control
   ////////////////////////////////////////
   reset_control #(
      .RESET_CNT_W (RESET_CNT_W)
   ) reset_control_i (
      .clk        (clk),
      .reset      (reset),
      .m_valid    (m_valid),
      .m_addr     (m_addr),
      .m_wstrb    (m_wstrb),
      .mem_sel    (mem_sel),
      .core_reset (core_reset),
      .sys_ready  (sys_ready)
   );

   ////////////////////////////////////////
   // interconnect
   ////////////////////////////////////////
   bus_interconnect bus_interconnect_i (
      .clk        (clk),
      .reset      (reset),
      .mem_sel    (mem_sel),
      .m_valid    (m_valid),
      .m_addr     (m_addr),
      .s_valid    (s_valid),
      .m_rdata    (m_rdata),
      .m_ready    (m_ready),
      .boot_rdata (boot_rdata),
      .main_rdata (main_rdata),
      .uart_rdata (uart_rdata),
      .s_ready    (s_ready)
   );

   ////////////////////////////////////////
   // slaves
   ////////////////////////////////////////
   // addr, wdata and wstrb broadcast to all slaves
   sram_bank #(
      .ADDR_W (BOOT_ADDR_W)
   ) boot_mem (
      .clk   (clk),
      .valid (s_valid[SLV_BOOT]),
      .addr  (m_addr[BOOT_ADDR_W-1:0]),
      .wdata (m_wdata),
      .wstrb (m_wstrb),
      .rdata (boot_rdata),
      .ready (s_ready[SLV_BOOT])
   );

   sram_bank #(
      .ADDR_W (MAIN_ADDR_W)
   ) main_mem (
      .clk   (clk),
      .valid (s_valid[SLV_MAIN]),
      .addr  (m_addr[MAIN_ADDR_W-1:0]),
      .wdata (m_wdata),
      .wstrb (m_wstrb),
      .rdata (main_rdata),
      .ready (s_ready[SLV_MAIN])
   );

   // word index picks the register
   uart_core #(
      .UART_DIV_RESET (UART_DIV_RESET)
   ) uart_i (
      .clk    (clk),
      .reset  (reset),
      .valid  (s_valid[SLV_UART]),
      .addr   (m_addr[4:2]),
      .wdata  (m_wdata),
      .wstrb  (m_wstrb),
      .rdata  (uart_rdata),
      .ready  (s_ready[SLV_UART]),
      .ser_rx (ser_rx),
      .ser_tx (ser_tx)
   );

endmodule

`default_nettype wire

//--- test/soc_system_tb.sv
`default_nettype none

module soc_system_tb;
   import soc_pkg::*;

   localparam int          POR_W      = 4;
   localparam int          TB_DIV     = 12;
   localparam int          TIMEOUT    = 2000;
   // words touched per bank, index is addr[5:2]
   localparam int          N_WORDS    = 16;
   localparam logic [31:0] BOOT_BASE  = 32'h0000_0000;
   localparam logic [31:0] MAIN_BASE  = 32'h2000_0000;
   localparam logic [31:0] UART_BASE  = 32'h4000_0000;
   localparam logic [31:0] UNMAP_ADDR = 32'h8000_0010;
   localparam logic [31:0] TX_ADDR    = {UART_BASE[31:5], UART_TXDATA, 2'b00};
   localparam logic [31:0] STAT_ADDR  = {UART_BASE[31:5], UART_STATUS, 2'b00};
   localparam logic [31:0] RX_ADDR    = {UART_BASE[31:5], UART_RXDATA, 2'b00};
   localparam logic [31:0] DIV_ADDR   = {UART_BASE[31:5], UART_DIV, 2'b00};

   logic        clk = 1'b0;
   logic        reset;
   logic        m_valid;
   logic [31:0] m_addr;
   logic [31:0] m_wdata;
   logic [3:0]  m_wstrb;
   logic [31:0] m_rdata;
   logic        m_ready;
   logic        core_reset;
   logic        sys_ready;
   logic        mem_sel;
   logic        ser_rx;
   logic        ser_tx;

   integer      seed;
   int          errors;
   int          checks;
   int          soft_rst_cycles;
   // reference memories and remap state
   logic [31:0] boot_ref [N_WORDS];
   logic [31:0] main_ref [N_WORDS];
   logic        remap_ref;

   soc_system #(
      .BOOT_ADDR_W    (12),
      .MAIN_ADDR_W    (14),
      .RESET_CNT_W    (POR_W),
      .UART_DIV_RESET (16)
   ) soc_system_i (
      .clk        (clk),
      .reset      (reset),
      .m_valid    (m_valid),
      .m_addr     (m_addr),
      .m_wdata    (m_wdata),
      .m_wstrb    (m_wstrb),
      .m_rdata    (m_rdata),
      .m_ready    (m_ready),
      .core_reset (core_reset),
      .sys_ready  (sys_ready),
      .mem_sel    (mem_sel),
      .ser_rx     (ser_rx),
      .ser_tx     (ser_tx)
   );

   always #10 clk = ~clk;

   // core reset cycles once power-on is done
   always @(negedge clk) begin
      if (sys_ready && core_reset) begin
         soft_rst_cycles = soft_rst_cycles + 1;
      end
   end

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////
   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
      logic [31:0] result;
      result = old_word;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            result[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return result;
   endfunction

   function automatic logic [31:0] word_addr(input logic [31:0] base, input logic [3:0] idx);
      return base | {26'd0, idx, 2'b00};
   endfunction

   // region 0 follows the remap flag, region 1 is always main
   function automatic void ref_write(input logic [31:0] addr, input logic [31:0] data,
                                     input logic [3:0] strb);
      logic [3:0] idx;
      idx = addr[5:2];
      if (addr[31:29] == REGION_BOOT && !remap_ref) begin
         boot_ref[idx] = merge_bytes(boot_ref[idx], data, strb);
      end else if (addr[31:29] == REGION_BOOT || addr[31:29] == REGION_MAIN) begin
         main_ref[idx] = merge_bytes(main_ref[idx], data, strb);
      end
   endfunction

   function automatic logic [31:0] ref_read(input logic [31:0] addr);
      logic [3:0] idx;
      idx = addr[5:2];
      if (addr[31:29] == REGION_BOOT && !remap_ref) begin
         return boot_ref[idx];
      end else if (addr[31:29] == REGION_BOOT || addr[31:29] == REGION_MAIN) begin
         return main_ref[idx];
      end
      // unmapped reads as zero
      return '0;
   endfunction

   ////////////////////////////////////////
   // checking and bus tasks
   ////////////////////////////////////////
   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic abort_on_timeout(input string what);
      $display("timeout while waiting for %s", what);
      $display("errors: %0d, checks: %0d", errors, checks);
      $display("=== FAIL ===");
      $finish;
   endtask

   // entered just after a rising edge, leaves the same way
   task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb, output logic [31:0] rdata);
      int   cycles;
      logic seen;
      cycles  = 0;
      seen    = 1'b0;
      m_valid = 1'b1;
      m_addr  = addr;
      m_wdata = wdata;
      m_wstrb = wstrb;
      while (!seen) begin
         @(posedge clk);
         cycles++;
         @(negedge clk);
         seen = m_ready;
         if (!seen && cycles >= TIMEOUT) begin
            abort_on_timeout("m_ready");
         end
      end
      rdata = m_rdata;
      // ready one cycle after valid, every region
      check_value("bus_timing", 32'd1, 32'(cycles));
      @(posedge clk);
      #1;
      m_valid = 1'b0;
      m_wstrb = '0;
   endtask

   task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      logic [31:0] unused;
      bus_access(addr, data, strb, unused);
   endtask

   task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
      bus_access(addr, 32'd0, 4'd0, data);
   endtask

   ////////////////////////////////////////
   // serial line
   ////////////////////////////////////////
   // 8N1, samples taken mid-bit on falling clock edges
   task automatic decode_tx_frame(input int div, output logic [7:0] value);
      int         waited;
      logic [9:0] bits;
      waited = 0;
      @(negedge clk);
      while (ser_tx) begin
         @(negedge clk);
         waited++;
         if (ser_tx && waited >= TIMEOUT) begin
            abort_on_timeout("tx start bit");
         end
      end
      repeat (div / 2) @(negedge clk);
      for (int k = 0; k < 10; k++) begin
         bits[k] = ser_tx;
         if (k < 9) begin
            repeat (div) @(negedge clk);
         end
      end
      check_value("uart_tx_start_bit", 32'd0, 32'(bits[0]));
      check_value("uart_tx_stop_bit", 32'd1, 32'(bits[9]));
      value = bits[8:1];
   endtask

   task automatic send_rx_frame(input logic [7:0] value, input int div);
      logic [9:0] bits;
      bits = {1'b1, value, 1'b0};
      for (int k = 0; k < 10; k++) begin
         ser_rx = bits[k];
         repeat (div) @(posedge clk);
         #1;
      end
   endtask

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////
   initial begin
      logic [31:0] rd;
      logic [31:0] rnd;
      logic [31:0] wr_data;
      logic [31:0] addr;
      logic [7:0]  tx_byte;
      logic [7:0]  tx_got;
      logic [7:0]  rx_byte;
      logic        flag;
      int          cycles;

      seed            = 32'h8310_421a;
      errors          = 0;
      checks          = 0;
      soft_rst_cycles = 0;
      remap_ref       = 1'b0;
      reset           = 1'b1;
      m_valid         = 1'b0;
      m_addr          = '0;
      m_wdata         = '0;
      m_wstrb         = '0;
      ser_rx          = 1'b1;

      // state during reset
      @(negedge clk);
      check_value("reset_core_reset", 32'd1, 32'(core_reset));
      check_value("reset_sys_ready", 32'd0, 32'(sys_ready));
      check_value("reset_mem_sel", 32'd0, 32'(mem_sel));
      check_value("reset_ser_tx", 32'd1, 32'(ser_tx));
      // release after the third rising edge under reset
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;

      // power-on counter, top bit after 2^(w-1) edges
      cycles = 0;
      while (!sys_ready) begin
         check_value("por_core_reset_high", 32'd1, 32'(core_reset));
         @(posedge clk);
         cycles++;
         @(negedge clk);
         if (!sys_ready && cycles >= TIMEOUT) begin
            abort_on_timeout("sys_ready");
         end
      end
      check_value("por_cycles", 32'(1 << (POR_W - 1)), 32'(cycles));
      check_value("por_core_reset_low", 32'd0, 32'(core_reset));
      @(posedge clk);
      #1;

      // main memory, full fill then partial strobes
      for (int i = 0; i < N_WORDS; i++) begin
         rnd  = $random(seed);
         addr = word_addr(MAIN_BASE, 4'(i));
         bus_write(addr, rnd, 4'hf);
         ref_write(addr, rnd, 4'hf);
      end
      for (int n = 0; n < 40; n++) begin
         rnd     = $random(seed);
         wr_data = $random(seed);
         addr    = word_addr(MAIN_BASE, rnd[3:0]);
         bus_write(addr, wr_data, rnd[7:4]);
         ref_write(addr, wr_data, rnd[7:4]);
      end
      for (int i = 0; i < N_WORDS; i++) begin
         addr = word_addr(MAIN_BASE, 4'(i));
         bus_read(addr, rd);
         check_value("main_readback", ref_read(addr), rd);
      end
      bus_read(UNMAP_ADDR, rd);
      check_value("unmapped_read", ref_read(UNMAP_ADDR), rd);

      // boot memory, separate from main before remap
      for (int i = 0; i < N_WORDS; i++) begin
         rnd  = $random(seed);
         addr = word_addr(BOOT_BASE, 4'(i));
         bus_write(addr, rnd, 4'hf);
         ref_write(addr, rnd, 4'hf);
      end
      for (int i = 0; i < N_WORDS; i++) begin
         addr = word_addr(BOOT_BASE, 4'(i));
         bus_read(addr, rd);
         check_value("boot_readback", ref_read(addr), rd);
         addr = word_addr(MAIN_BASE, 4'(i));
         bus_read(addr, rd);
         check_value("boot_main_untouched", ref_read(addr), rd);
      end

      // soft reset and remap
      soft_rst_cycles = 0;
      bus_write(SOFT_RESET_ADDR, 32'h1, 4'hf);
      remap_ref = 1'b1;
      check_value("soft_mem_sel", 32'd1, 32'(mem_sel));
      cycles = 0;
      while (core_reset) begin
         @(negedge clk);
         cycles++;
         if (core_reset && cycles >= TIMEOUT) begin
            abort_on_timeout("core_reset release");
         end
      end
      check_value("soft_core_reset_cycles", 32'(SOFT_RESET_CYCLES), 32'(soft_rst_cycles));
      @(posedge clk);
      #1;
      for (int i = 0; i < N_WORDS; i++) begin
         addr = word_addr(BOOT_BASE, 4'(i));
         bus_read(addr, rd);
         check_value("remap_read", ref_read(addr), rd);
      end

      // uart transmit, second write lands while busy
      bus_write(DIV_ADDR, 32'(TB_DIV), 4'b0011);
      bus_read(DIV_ADDR, rd);
      check_value("uart_div", 32'(TB_DIV), rd);
      rnd     = $random(seed);
      tx_byte = rnd[7:0];
      fork
         decode_tx_frame(TB_DIV, tx_got);
         begin
            bus_write(TX_ADDR, {24'd0, tx_byte}, 4'h1);
            bus_read(STAT_ADDR, rd);
            check_value("uart_tx_busy", 32'd1, 32'(rd[0]));
            bus_write(TX_ADDR, {24'd0, ~tx_byte}, 4'h1);
         end
      join
      check_value("uart_tx_byte", 32'(tx_byte), 32'(tx_got));
      @(posedge clk);
      #1;
      flag   = 1'b1;
      cycles = 0;
      while (flag) begin
         bus_read(STAT_ADDR, rd);
         flag = rd[0];
         cycles++;
         if (flag && cycles >= TIMEOUT) begin
            abort_on_timeout("tx busy to clear");
         end
      end

      // uart receive
      rnd     = $random(seed);
      rx_byte = rnd[7:0];
      send_rx_frame(rx_byte, TB_DIV);
      flag   = 1'b0;
      cycles = 0;
      while (!flag) begin
         bus_read(STAT_ADDR, rd);
         flag = rd[1];
         cycles++;
         if (!flag && cycles >= TIMEOUT) begin
            abort_on_timeout("rx valid");
         end
      end
      bus_read(RX_ADDR, rd);
      check_value("uart_rx_data", 32'(rx_byte), rd);
      bus_read(STAT_ADDR, rd);
      check_value("uart_rx_valid_clear", 32'd0, 32'(rd[1]));

      $display("errors: %0d, checks: %0d", errors, checks);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
design/soc_pkg.sv
design/reset_control.sv
design/bus_interconnect.sv
design/sram_bank.sv
design/uart_core.sv
design/soc_system.sv
test/soc_system_tb.sv
